// File: fm_lite.f
source/fm_lite_pkg.sv
source/fm_regs.sv
source/fm_voice.sv
source/fm_mixer.sv
source/fm_lite.sv
tests/fm_lite_properties.sv
tests/fm_lite_tb.sv

// File: source/fm_lite.sv
`timescale 1ns/1ns

module fm_lite (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 write,   // one-cycle host strobe
    input  logic                                 addr,    // 0 address, 1 data
    input  logic [7:0]                           din,
    output logic signed [fm_lite_pkg::MIX_W-1:0] snd_left,
    output logic signed [fm_lite_pkg::MIX_W-1:0] snd_right,
    output logic                                 snd_sample
);
    import fm_lite_pkg::*;

    ch_cfg_t    [NUM_CH-1:0] cfg;
    voice_out_t [NUM_CH-1:0] voices;
    logic       [NUM_CH-1:0] voice_valid;
    logic                    sample_tick;

    fm_regs u_regs (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .write       ( write       ),
        .addr        ( addr        ),
        .din         ( din         ),
        .cfg         ( cfg         ),
        .sample_tick ( sample_tick )
    );

    // voices share the tick and stay in lockstep
    generate
        for (genvar i = 0; i < NUM_CH; i++) begin : g_voice
            fm_voice u_voice (
                .clk         ( clk            ),
                .reset       ( reset          ),
                .cfg         ( cfg[i]         ),
                .sample_tick ( sample_tick    ),
                .voice       ( voices[i]      ),
                .voice_valid ( voice_valid[i] )
            );
        end
    endgenerate

    // voice 0 strobe stands for all of them
    fm_mixer u_mixer (
        .clk         ( clk            ),
        .reset       ( reset          ),
        .voices      ( voices         ),
        .voice_valid ( voice_valid[0] ),
        .snd_left    ( snd_left       ),
        .snd_right   ( snd_right      ),
        .snd_sample  ( snd_sample     )
    );

endmodule

// File: source/fm_lite_pkg.sv
package fm_lite_pkg;

    // voices and sample rate
    localparam int NUM_CH     = 4;
    localparam int SAMPLE_DIV = 8;   // clock cycles per sample tick
    localparam int TICK_W     = $clog2(SAMPLE_DIV);

    // datapath widths
    localparam int PHASE_W   = 16;
    localparam int VOICE_W   = 12;   // signed voice sample
    localparam int MIX_W     = 16;   // signed mixed output
    localparam int MIX_SHIFT = 2;    // mixer gain of 4

    // host register map
    localparam int ADDR_W = 8;
    localparam logic [ADDR_W-1:0] REG_FNUM  = 8'h10;  // + channel
    localparam logic [ADDR_W-1:0] REG_BLOCK = 8'h20;  // + channel
    localparam logic [ADDR_W-1:0] REG_KEYON = 8'h28;  // one key bit per channel
    localparam logic [ADDR_W-1:0] REG_LEVEL = 8'h30;  // + channel

    // level register layout
    localparam int LVL_PAN_L = 7;
    localparam int LVL_PAN_R = 6;

    // settings of one channel, 17 bits
    typedef struct packed {
        logic [7:0] fnum;
        logic [2:0] block;
        logic [2:0] atten;   // arithmetic right shift of the wave
        logic       pan_l;
        logic       pan_r;
        logic       keyon;
    } ch_cfg_t;

    // one voice result, 14 bits
    // pan travels with the value it was produced under
    typedef struct packed {
        logic signed [VOICE_W-1:0] value;
        logic                      pan_l;
        logic                      pan_r;
    } voice_out_t;

endpackage

// File: source/fm_mixer.sv
`timescale 1ns/1ns

module fm_mixer (
    input  logic                                              clk,
    input  logic                                              reset,
    input  fm_lite_pkg::voice_out_t [fm_lite_pkg::NUM_CH-1:0] voices,
    input  logic                                              voice_valid,
    output logic signed [fm_lite_pkg::MIX_W-1:0]              snd_left,
    output logic signed [fm_lite_pkg::MIX_W-1:0]              snd_right,
    output logic                                              snd_sample
);
    import fm_lite_pkg::*;

    logic signed [MIX_W-1:0] extended;
    logic signed [MIX_W-1:0] sum_left;
    logic signed [MIX_W-1:0] sum_right;

    // four 12-bit voices need 14 bits, the gain of 4 fills the rest
    always_comb begin
        sum_left  = '0;
        sum_right = '0;
        extended  = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            extended = {{(MIX_W-VOICE_W){voices[ch].value[VOICE_W-1]}},
                        voices[ch].value};
            if (voices[ch].pan_l) begin
                sum_left = sum_left + extended;
            end
            if (voices[ch].pan_r) begin
                sum_right = sum_right + extended;
            end
        end
    end

    // outputs only move together with the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= voice_valid;
            if (voice_valid) begin
                snd_left  <= sum_left <<< MIX_SHIFT;
                snd_right <= sum_right <<< MIX_SHIFT;
            end
        end
    end

endmodule

// File: source/fm_regs.sv
`timescale 1ns/1ns

module fm_regs (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        write,
    input  logic                                        addr,
    input  logic [7:0]                                  din,
    output fm_lite_pkg::ch_cfg_t [fm_lite_pkg::NUM_CH-1:0] cfg,
    output logic                                        sample_tick
);
    import fm_lite_pkg::*;

    logic [ADDR_W-1:0] reg_addr;    // latched register address
    logic              data_wr;
    logic [NUM_CH-1:0] hit_fnum;
    logic [NUM_CH-1:0] hit_block;
    logic [NUM_CH-1:0] hit_level;
    logic              hit_keyon;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick_wrap;

    assign data_wr = write && addr;

    // address phase of the host port
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_addr <= '0;
        end else if (write && !addr) begin
            reg_addr <= din;
        end
    end

    // decode the latched address against the per-channel banks
    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            hit_fnum[ch]  = (reg_addr == ADDR_W'(REG_FNUM + ch));
            hit_block[ch] = (reg_addr == ADDR_W'(REG_BLOCK + ch));
            hit_level[ch] = (reg_addr == ADDR_W'(REG_LEVEL + ch));
        end
    end

    assign hit_keyon = (reg_addr == REG_KEYON);

    // data phase, unmapped addresses match nothing and fall through
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (data_wr) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (hit_fnum[ch]) begin
                    cfg[ch].fnum <= din;
                end
                if (hit_block[ch]) begin
                    cfg[ch].block <= din[2:0];
                end
                if (hit_level[ch]) begin
                    cfg[ch].atten <= din[2:0];
                    cfg[ch].pan_l <= din[LVL_PAN_L];
                    cfg[ch].pan_r <= din[LVL_PAN_R];
                end
                // key register sets every channel in one write
                if (hit_keyon) begin
                    cfg[ch].keyon <= din[ch];
                end
            end
        end
    end

    // sample prescaler
    // the first tick lands in the 8th cycle out of reset
    assign tick_wrap = (tick_cnt == TICK_W'(SAMPLE_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt    <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= tick_wrap;
            if (tick_wrap) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

// File: source/fm_voice.sv
`timescale 1ns/1ns

module fm_voice (
    input  logic                    clk,
    input  logic                    reset,
    input  fm_lite_pkg::ch_cfg_t    cfg,
    input  logic                    sample_tick,
    output fm_lite_pkg::voice_out_t voice,
    output logic                    voice_valid
);
    import fm_lite_pkg::*;

    logic        [PHASE_W-1:0] phase;
    logic        [PHASE_W-1:0] phase_inc;
    logic        [VOICE_W-2:0] ramp;      // position inside half a period
    logic signed [VOICE_W-1:0] rising;
    logic signed [VOICE_W-1:0] wave;
    logic signed [VOICE_W-1:0] shaped;

    // fnum scaled by octave, wraps at 2^16
    assign phase_inc = PHASE_W'(cfg.fnum) << cfg.block;

    // triangle from the top 12 phase bits
    assign ramp = phase[PHASE_W-2 -: VOICE_W-1];

    // 2*t - 2048 on the way up: double the ramp, flip the sign bit
    assign rising = {~ramp[VOICE_W-2], ramp[VOICE_W-3:0], 1'b0};

    // second half mirrors the first, ~x is 2047 - 2*(t - 2048)
    assign wave = phase[PHASE_W-1] ? ~rising : rising;

    assign shaped = wave >>> cfg.atten;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= '0;
            voice_valid <= 1'b0;
        end else begin
            voice_valid <= sample_tick;
            if (sample_tick) begin
                if (cfg.keyon) begin
                    phase <= phase + phase_inc;
                end else begin
                    phase <= '0;   // key off parks the phase
                end
            end
        end
    end

    // sample register, loaded in the same tick as the phase step
    always_ff @(posedge clk) begin
        if (sample_tick) begin
            voice.value <= cfg.keyon ? shaped : '0;
            voice.pan_l <= cfg.pan_l;
            voice.pan_r <= cfg.pan_r;
        end
    end

endmodule

// File: tests/fm_lite_properties.sv
`timescale 1ns/1ns

module fm_lite_properties (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 snd_sample,
    input logic signed [fm_lite_pkg::MIX_W-1:0] snd_left,
    input logic signed [fm_lite_pkg::MIX_W-1:0] snd_right
);
    import fm_lite_pkg::*;

    int violations = 0;   // read by the testbench at the end

    // strobe lasts one cycle
    strobe_single: assert property (@(posedge clk) disable iff (reset)
        snd_sample |=> !snd_sample)
        else begin
            violations++;
            $error("snd_sample high for two cycles in a row");
        end

    // one pulse per sample period
    strobe_spacing: assert property (@(posedge clk) disable iff (reset)
        snd_sample |=> !snd_sample [*SAMPLE_DIV-1] ##1 snd_sample)
        else begin
            violations++;
            $error("snd_sample pulses not SAMPLE_DIV cycles apart");
        end

    output_hold: assert property (@(posedge clk) disable iff (reset)
        !snd_sample |-> $stable(snd_left) && $stable(snd_right))
        else begin
            violations++;
            $error("outputs changed without snd_sample");
        end

endmodule

bind fm_lite fm_lite_properties u_props (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .snd_sample ( snd_sample ),
    .snd_left   ( snd_left   ),
    .snd_right  ( snd_right  )
);

// File: tests/fm_lite_tb.sv
`timescale 1ns/1ns

module fm_lite_tb;
    import fm_lite_pkg::*;

    logic                    clk;
    logic                    reset;
    logic                    write;
    logic                    addr;
    logic [7:0]              din;
    logic signed [MIX_W-1:0] snd_left;
    logic signed [MIX_W-1:0] snd_right;
    logic                    snd_sample;

    integer seed;
    int     cycles = 0;

    // reference model state per channel
    int m_fnum  [NUM_CH];
    int m_block [NUM_CH];
    int m_atten [NUM_CH];
    int m_pan_l [NUM_CH];
    int m_pan_r [NUM_CH];
    int m_key   [NUM_CH];
    int m_phase [NUM_CH];
    int exp_left;
    int exp_right;

    fm_lite u_dut (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .write      ( write      ),
        .addr       ( addr       ),
        .din        ( din        ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // about 420 sample periods of tests plus margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 500 * SAMPLE_DIV) begin
            $display("timeout: the run did not finish within %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check(input string name, input integer expected, input integer actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // triangle of a 16-bit phase over its top 12 bits
    function automatic int tri_wave(input int ph);
        int t;
        t = (ph >> 4) & 12'hfff;
        if (t < 2048) begin
            return 2 * t - 2048;
        end else begin
            return 2047 - 2 * (t - 2048);
        end
    endfunction

    // register decode of the model
    task automatic apply_write(input logic [7:0] a, input logic [7:0] d);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (a == REG_FNUM + ch) begin
                m_fnum[ch] = d;
            end
            if (a == REG_BLOCK + ch) begin
                m_block[ch] = d & 7;
            end
            if (a == REG_LEVEL + ch) begin
                m_atten[ch] = d & 7;
                m_pan_l[ch] = d[7];
                m_pan_r[ch] = d[6];
            end
            if (a == REG_KEYON) begin
                m_key[ch] = d[ch];
            end
        end
    endtask

    // one sample period of voices and mixer
    task automatic step_model;
        int v;
        int left;
        int right;
        left  = 0;
        right = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (m_key[ch] != 0) begin
                v = tri_wave(m_phase[ch]) >>> m_atten[ch];
                m_phase[ch] = (m_phase[ch] + ((m_fnum[ch] << m_block[ch]) & 16'hffff)) & 16'hffff;
            end else begin
                v = 0;
                m_phase[ch] = 0;
            end
            if (m_pan_l[ch] != 0) left = left + v;
            if (m_pan_r[ch] != 0) right = right + v;
        end
        exp_left  = left * 4;
        exp_right = right * 4;
    endtask

    // address then data strobe 3 cycles after a sample pulse
    task automatic host_write(input logic [7:0] a, input logic [7:0] d);
        repeat (3) @(posedge clk);
        write <= 1'b1;
        addr  <= 1'b0;
        din   <= a;
        @(posedge clk);
        addr  <= 1'b1;
        din   <= d;
        @(posedge clk);
        write <= 1'b0;
        addr  <= 1'b0;
        apply_write(a, d);
    endtask

    task automatic wait_sample;
        @(negedge clk);
        while (!snd_sample) @(negedge clk);
    endtask

    task automatic run_sample(input string name);
        wait_sample();
        step_model();
        check({name, " left"}, exp_left, snd_left);
        check({name, " right"}, exp_right, snd_right);
    endtask

    initial begin
        int          latency;
        int          sel;
        int          ch;
        logic [7:0]  a;
        logic [7:0]  d;
        seed  = 32'h44c0;
        reset = 1'b1;
        write = 1'b0;
        addr  = 1'b0;
        din   = 8'h00;
        for (int i = 0; i < NUM_CH; i++) begin
            m_fnum[i]  = 0;
            m_block[i] = 0;
            m_atten[i] = 0;
            m_pan_l[i] = 0;
            m_pan_r[i] = 0;
            m_key[i]   = 0;
            m_phase[i] = 0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // reset state and first pulse latency
        latency = 0;
        @(negedge clk);
        while (!snd_sample) begin
            latency++;
            @(negedge clk);
        end
        check("reset latency", 10, latency);
        step_model();
        check("reset left", 0, snd_left);
        check("reset right", 0, snd_right);

        // single tone on channel 0 panned to both sides
        host_write(REG_FNUM, ($random(seed) & 8'hff) | 8'h01);
        run_sample("single tone");
        host_write(REG_BLOCK, $random(seed) & 7);
        run_sample("single tone");
        host_write(REG_LEVEL, 8'hc0);
        run_sample("single tone");
        host_write(REG_KEYON, 8'h01);
        run_sample("single tone");
        check("single tone start left", -8192, snd_left);
        check("single tone start right", -8192, snd_right);
        repeat (99) run_sample("single tone");

        // pan and attenuation on channel 1 with channel 0 keyed off
        host_write(REG_FNUM + 1, ($random(seed) & 8'hff) | 8'h01);
        run_sample("pan atten");
        host_write(REG_BLOCK + 1, $random(seed) & 7);
        run_sample("pan atten");
        host_write(REG_LEVEL + 1, $random(seed) & 8'hc7);
        run_sample("pan atten");
        host_write(REG_KEYON, 8'h02);
        run_sample("pan atten");
        repeat (4) begin
            host_write(REG_LEVEL + 1, $random(seed) & 8'hc7);
            repeat (2) begin
                run_sample("pan atten");
                if (m_pan_l[1] == 0) check("pan off left", 0, snd_left);
                if (m_pan_r[1] == 0) check("pan off right", 0, snd_right);
            end
        end

        // key-off silences and key-on restarts from phase 0
        host_write(REG_KEYON, 8'h00);
        repeat (3) begin
            run_sample("key-off");
            check("key-off left", 0, snd_left);
            check("key-off right", 0, snd_right);
        end
        host_write(REG_KEYON, 8'h02);
        repeat (5) run_sample("key-on again");

        // random register traffic including unmapped addresses
        repeat (300) begin
            run_sample("random mix");
            sel = $random(seed) & 7;
            ch  = $random(seed) & 3;
            d   = $random(seed) & 8'hff;
            case (sel)
                0, 1: a = REG_FNUM + ch;
                2:    a = REG_BLOCK + ch;
                3, 4: a = REG_LEVEL + ch;
                5:    a = REG_KEYON;
                default: a = $random(seed) & 8'hff;   // mostly unmapped
            endcase
            if (sel != 7) host_write(a, d);
        end

        // bound assertions count their failures
        if (u_dut.u_props.violations == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", u_dut.u_props.violations);
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failures");
        end
    end

endmodule
